//--- cpu_params_pkg.sv
`default_nettype none

package cpu_params_pkg;

    //////////////////////////////////////////////////////////////////////
    // Dispatch and station sizing
    //////////////////////////////////////////////////////////////////////

    localparam int ID_WIDTH   = 2;      // Micro-ops per dispatch group
    localparam int NUM_RS     = 4;      // INT, INTM, BR, MEM
    localparam int RS_DEPTH   = 4;      // Entries per station
    localparam int TAG_WIDTH  = 5;      // Physical register tag
    localparam int PERF_WIDTH = 32;

    // Entry index and age share one width, ages run 0 .. RS_DEPTH-1
    localparam int RS_IDX_WIDTH = $clog2(RS_DEPTH);
    localparam int RS_CNT_WIDTH = $clog2(RS_DEPTH + 1);   // Holds 0 .. RS_DEPTH

    //////////////////////////////////////////////////////////////////////
    // Functional unit latencies
    //////////////////////////////////////////////////////////////////////

    localparam int LAT_INT  = 1;
    localparam int LAT_INTM = 3;
    localparam int LAT_BR   = 1;
    localparam int LAT_MEM  = 2;

    localparam int MAX_LAT_ALU = (LAT_INT > LAT_INTM) ? LAT_INT : LAT_INTM;
    localparam int MAX_LAT_BM  = (LAT_BR > LAT_MEM) ? LAT_BR : LAT_MEM;
    localparam int MAX_LAT     = (MAX_LAT_ALU > MAX_LAT_BM) ? MAX_LAT_ALU : MAX_LAT_BM;

    // Indexed by station class, same order as rs_type_e
    localparam int RS_LAT [NUM_RS] = '{LAT_INT, LAT_INTM, LAT_BR, LAT_MEM};

endpackage

`default_nettype wire

//--- ds_stage.sv
`default_nettype none
`timescale 1ns/1ps

module ds_stage
    import cpu_params_pkg::*;
    import uop_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // Rename side
    input  logic                  prv_valid,
    output logic                  prv_ready,
    input  logic                  uops_valid   [ID_WIDTH],
    input  rs_type_e              uop_type     [ID_WIDTH],
    input  op_e                   uop_op       [ID_WIDTH],
    input  logic [TAG_WIDTH-1:0]  uop_dst      [ID_WIDTH],
    input  logic [TAG_WIDTH-1:0]  uop_src1     [ID_WIDTH],
    input  logic                  uop_src1_rdy [ID_WIDTH],
    input  logic [TAG_WIDTH-1:0]  uop_src2     [ID_WIDTH],
    input  logic                  uop_src2_rdy [ID_WIDTH],

    // Station side, fields are shared and only the strobes are per class
    input  logic                  rs_ready     [NUM_RS],
    output logic                  wr_valid     [NUM_RS][ID_WIDTH],
    output op_e                   wr_op        [ID_WIDTH],
    output logic [TAG_WIDTH-1:0]  wr_dst       [ID_WIDTH],
    output logic [TAG_WIDTH-1:0]  wr_src1      [ID_WIDTH],
    output logic [TAG_WIDTH-1:0]  wr_src2      [ID_WIDTH],
    output logic                  wr_src1_rdy  [ID_WIDTH],
    output logic                  wr_src2_rdy  [ID_WIDTH],

    output logic [PERF_WIDTH-1:0] perf_block   [NUM_RS]
);

    //////////////////////////////////////////////////////////////////////
    // Ready merge
    //////////////////////////////////////////////////////////////////////

    logic slot_ready [ID_WIDTH];
    logic slot0_block;

    // An empty slot never holds the group back
    generate for (genvar i = 0; i < ID_WIDTH; i++) begin : g_slot_ready
        assign slot_ready[i] = !uops_valid[i] || rs_ready[uop_type[i]];
    end endgenerate

    always_comb begin : ready_merge
        prv_ready = 1'b1;
        for (int i = 0; i < ID_WIDTH; i++) begin
            prv_ready = prv_ready && slot_ready[i];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Class decode
    //////////////////////////////////////////////////////////////////////

    generate for (genvar c = 0; c < NUM_RS; c++) begin : g_route_rs
        for (genvar i = 0; i < ID_WIDTH; i++) begin : g_route_slot
            assign wr_valid[c][i] = prv_valid && prv_ready && uops_valid[i]
                                 && (uop_type[i] == rs_type_e'(c));
        end
    end endgenerate

    generate for (genvar i = 0; i < ID_WIDTH; i++) begin : g_fields
        assign wr_op[i]       = uop_op[i];
        assign wr_dst[i]      = uop_dst[i];
        assign wr_src1[i]     = uop_src1[i];
        assign wr_src2[i]     = uop_src2[i];
        assign wr_src1_rdy[i] = uop_src1_rdy[i];
        assign wr_src2_rdy[i] = uop_src2_rdy[i];
    end endgenerate

    //////////////////////////////////////////////////////////////////////
    // Block counters
    //////////////////////////////////////////////////////////////////////

    // Charged to slot 0's class, and only when slot 0 itself stalls
    assign slot0_block = prv_valid && !slot_ready[0];

    always_ff @(posedge clk) begin : perf_cnt
        if (rst) begin
            for (int c = 0; c < NUM_RS; c++) begin
                perf_block[c] <= '0;
            end
        end else if (slot0_block) begin
            perf_block[uop_type[0]] <= perf_block[uop_type[0]] + 1'b1;
        end
    end

    // Class of a live slot must be known, else routing and counting go astray
    generate for (genvar i = 0; i < ID_WIDTH; i++) begin : g_chk_type
        a_type_known: assert property (
            @(posedge clk) disable iff (rst)
            prv_valid && uops_valid[i] |-> !$isunknown(uop_type[i])
        );
    end endgenerate

endmodule

`default_nettype wire

//--- exec_writeback.sv
`default_nettype none
`timescale 1ns/1ps

module exec_writeback
    import cpu_params_pkg::*;
    import uop_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 iss_valid [NUM_RS],
    input  logic [TAG_WIDTH-1:0] iss_dst   [NUM_RS],
    input  op_e                  iss_op    [NUM_RS],

    output logic                 cmp_valid [NUM_RS],
    output logic [TAG_WIDTH-1:0] cmp_dst   [NUM_RS],
    output op_e                  cmp_op    [NUM_RS]
);

    //////////////////////////////////////////////////////////////////////
    // Per-class shift pipelines
    //////////////////////////////////////////////////////////////////////

    logic                 pipe_valid [NUM_RS][MAX_LAT];
    logic [TAG_WIDTH-1:0] pipe_dst   [NUM_RS][MAX_LAT];
    op_e                  pipe_op    [NUM_RS][MAX_LAT];

    always_ff @(posedge clk) begin : pipe_ctrl
        if (rst) begin
            for (int c = 0; c < NUM_RS; c++) begin
                for (int s = 0; s < MAX_LAT; s++) begin
                    pipe_valid[c][s] <= 1'b0;
                end
            end
        end else begin
            for (int c = 0; c < NUM_RS; c++) begin
                pipe_valid[c][0] <= iss_valid[c];   // One op per class per cycle
                for (int s = 1; s < MAX_LAT; s++) begin
                    pipe_valid[c][s] <= pipe_valid[c][s-1];
                end
            end
        end
    end

    always_ff @(posedge clk) begin : pipe_data
        for (int c = 0; c < NUM_RS; c++) begin
            pipe_dst[c][0] <= iss_dst[c];
            pipe_op[c][0]  <= iss_op[c];
            for (int s = 1; s < MAX_LAT; s++) begin
                pipe_dst[c][s] <= pipe_dst[c][s-1];
                pipe_op[c][s]  <= pipe_op[c][s-1];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Completion taps
    //////////////////////////////////////////////////////////////////////

    // Stage s holds ops issued s+1 cycles ago
    generate for (genvar c = 0; c < NUM_RS; c++) begin : g_tap
        assign cmp_valid[c] = pipe_valid[c][RS_LAT[c]-1];
        assign cmp_dst[c]   = pipe_dst[c][RS_LAT[c]-1];
        assign cmp_op[c]    = pipe_op[c][RS_LAT[c]-1];

        a_cmp_has_issue: assert property (
            @(posedge clk) disable iff (rst)
            cmp_valid[c] |-> $past(iss_valid[c], RS_LAT[c])
                          && cmp_dst[c] == $past(iss_dst[c], RS_LAT[c])
                          && cmp_op[c] == $past(iss_op[c], RS_LAT[c])
        );
    end endgenerate

endmodule

`default_nettype wire

//--- ooo_backend.f
cpu_params_pkg.sv
uop_types_pkg.sv
ds_stage.sv
rs_queue.sv
exec_writeback.sv
ooo_backend_top.sv
tb_ooo_backend.sv

//--- ooo_backend_top.sv
`default_nettype none
`timescale 1ns/1ps

module ooo_backend_top
    import cpu_params_pkg::*;
    import uop_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // Rename side
    input  logic                  prv_valid,
    output logic                  prv_ready,
    input  logic                  uops_valid   [ID_WIDTH],
    input  rs_type_e              uop_type     [ID_WIDTH],
    input  op_e                   uop_op       [ID_WIDTH],
    input  logic [TAG_WIDTH-1:0]  uop_dst      [ID_WIDTH],
    input  logic [TAG_WIDTH-1:0]  uop_src1     [ID_WIDTH],
    input  logic                  uop_src1_rdy [ID_WIDTH],
    input  logic [TAG_WIDTH-1:0]  uop_src2     [ID_WIDTH],
    input  logic                  uop_src2_rdy [ID_WIDTH],

    // Completion, one lane per class
    output logic                  cmp_valid    [NUM_RS],
    output logic [TAG_WIDTH-1:0]  cmp_dst      [NUM_RS],
    output op_e                   cmp_op       [NUM_RS],

    output logic [PERF_WIDTH-1:0] perf_block   [NUM_RS]
);

    logic                 rs_ready    [NUM_RS];
    logic                 wr_valid    [NUM_RS][ID_WIDTH];
    op_e                  wr_op       [ID_WIDTH];
    logic [TAG_WIDTH-1:0] wr_dst      [ID_WIDTH];
    logic [TAG_WIDTH-1:0] wr_src1     [ID_WIDTH];
    logic [TAG_WIDTH-1:0] wr_src2     [ID_WIDTH];
    logic                 wr_src1_rdy [ID_WIDTH];
    logic                 wr_src2_rdy [ID_WIDTH];
    logic                 iss_valid   [NUM_RS];
    logic [TAG_WIDTH-1:0] iss_dst     [NUM_RS];
    op_e                  iss_op      [NUM_RS];

    ds_stage u_ds (
        .clk, .rst,
        .prv_valid, .prv_ready, .uops_valid,
        .uop_type, .uop_op, .uop_dst,
        .uop_src1, .uop_src1_rdy, .uop_src2, .uop_src2_rdy,
        .rs_ready, .wr_valid, .wr_op, .wr_dst,
        .wr_src1, .wr_src2, .wr_src1_rdy, .wr_src2_rdy,
        .perf_block
    );

    // Station index equals rs_type_e value
    generate for (genvar c = 0; c < NUM_RS; c++) begin : g_rs
        rs_queue u_rs (
            .clk, .rst,
            .wr_valid    (wr_valid[c]),
            .wr_op, .wr_dst, .wr_src1, .wr_src1_rdy, .wr_src2, .wr_src2_rdy,
            .rs_ready    (rs_ready[c]),
            .cmp_valid, .cmp_dst,
            .iss_valid   (iss_valid[c]),
            .iss_dst     (iss_dst[c]),
            .iss_op      (iss_op[c])
        );
    end endgenerate

    exec_writeback u_exec (
        .clk, .rst,
        .iss_valid, .iss_dst, .iss_op,
        .cmp_valid, .cmp_dst, .cmp_op
    );

endmodule

`default_nettype wire

//--- rs_queue.sv
`default_nettype none
`timescale 1ns/1ps

module rs_queue
    import cpu_params_pkg::*;
    import uop_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    // Write ports from dispatch
    input  logic                 wr_valid    [ID_WIDTH],
    input  op_e                  wr_op       [ID_WIDTH],
    input  logic [TAG_WIDTH-1:0] wr_dst      [ID_WIDTH],
    input  logic [TAG_WIDTH-1:0] wr_src1     [ID_WIDTH],
    input  logic                 wr_src1_rdy [ID_WIDTH],
    input  logic [TAG_WIDTH-1:0] wr_src2     [ID_WIDTH],
    input  logic                 wr_src2_rdy [ID_WIDTH],
    output logic                 rs_ready,

    // Completion broadcast from every lane
    input  logic                 cmp_valid   [NUM_RS],
    input  logic [TAG_WIDTH-1:0] cmp_dst     [NUM_RS],

    // Issue strobe
    output logic                 iss_valid,
    output logic [TAG_WIDTH-1:0] iss_dst,
    output op_e                  iss_op
);

    // Tag match against any live completion lane
    function automatic logic tag_hit(
        input logic [TAG_WIDTH-1:0] tag,
        input logic                 lane_valid [NUM_RS],
        input logic [TAG_WIDTH-1:0] lane_dst   [NUM_RS]
    );
        logic hit;
        hit = 1'b0;
        for (int c = 0; c < NUM_RS; c++) begin
            if (lane_valid[c] && lane_dst[c] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Entry storage
    //////////////////////////////////////////////////////////////////////

    logic                    ent_valid    [RS_DEPTH];
    op_e                     ent_op       [RS_DEPTH];
    logic [TAG_WIDTH-1:0]    ent_dst      [RS_DEPTH];
    logic [TAG_WIDTH-1:0]    ent_src1     [RS_DEPTH];
    logic                    ent_src1_rdy [RS_DEPTH];
    logic [TAG_WIDTH-1:0]    ent_src2     [RS_DEPTH];
    logic                    ent_src2_rdy [RS_DEPTH];
    logic [RS_IDX_WIDTH-1:0] ent_age      [RS_DEPTH];  // 0 is the oldest live entry

    logic [RS_CNT_WIDTH-1:0] used_cnt;
    logic [RS_CNT_WIDTH-1:0] free_cnt;
    logic [RS_IDX_WIDTH-1:0] iss_idx;
    logic [RS_IDX_WIDTH-1:0] alloc_idx    [ID_WIDTH];
    logic [RS_IDX_WIDTH-1:0] alloc_age    [ID_WIDTH];
    logic                    any_wr;

    //////////////////////////////////////////////////////////////////////
    // Oldest-ready select
    //////////////////////////////////////////////////////////////////////

    always_comb begin : select
        iss_valid = 1'b0;
        iss_idx   = '0;
        used_cnt  = '0;
        for (int k = 0; k < RS_DEPTH; k++) begin
            if (ent_valid[k]) begin
                used_cnt = used_cnt + 1'b1;
            end
            if (ent_valid[k] && ent_src1_rdy[k] && ent_src2_rdy[k]) begin
                if (!iss_valid || ent_age[k] < ent_age[iss_idx]) begin
                    iss_valid = 1'b1;
                    iss_idx   = RS_IDX_WIDTH'(k);
                end
            end
        end
    end

    assign iss_dst  = ent_dst[iss_idx];
    assign iss_op   = ent_op[iss_idx];
    assign free_cnt = RS_CNT_WIDTH'(RS_DEPTH) - used_cnt;
    assign rs_ready = free_cnt >= RS_CNT_WIDTH'(ID_WIDTH);  // Room for a full group

    //////////////////////////////////////////////////////////////////////
    // Allocation, slot 0 first
    //////////////////////////////////////////////////////////////////////

    always_comb begin : alloc
        logic                    taken [RS_DEPTH];
        logic                    found;
        logic [RS_CNT_WIDTH-1:0] next_age;
        for (int k = 0; k < RS_DEPTH; k++) begin
            taken[k] = ent_valid[k];
        end
        next_age = used_cnt - RS_CNT_WIDTH'(iss_valid);   // Live count once issue leaves
        any_wr   = 1'b0;
        for (int i = 0; i < ID_WIDTH; i++) begin
            alloc_idx[i] = '0;
            alloc_age[i] = next_age[RS_IDX_WIDTH-1:0];
            found        = 1'b0;
            if (wr_valid[i]) begin
                any_wr = 1'b1;
                for (int k = 0; k < RS_DEPTH; k++) begin
                    if (!found && !taken[k]) begin
                        found        = 1'b1;
                        alloc_idx[i] = RS_IDX_WIDTH'(k);
                    end
                end
                taken[alloc_idx[i]] = 1'b1;
                next_age            = next_age + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // State update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin : valid_upd
        if (rst) begin
            for (int k = 0; k < RS_DEPTH; k++) begin
                ent_valid[k] <= 1'b0;
            end
        end else begin
            if (iss_valid) begin
                ent_valid[iss_idx] <= 1'b0;
            end
            for (int i = 0; i < ID_WIDTH; i++) begin
                if (wr_valid[i]) begin
                    ent_valid[alloc_idx[i]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin : payload_upd
        for (int k = 0; k < RS_DEPTH; k++) begin
            // Wakeup
            if (tag_hit(ent_src1[k], cmp_valid, cmp_dst)) begin
                ent_src1_rdy[k] <= 1'b1;
            end
            if (tag_hit(ent_src2[k], cmp_valid, cmp_dst)) begin
                ent_src2_rdy[k] <= 1'b1;
            end
            // Close the gap left by the issued entry
            if (iss_valid && ent_valid[k] && ent_age[k] > ent_age[iss_idx]) begin
                ent_age[k] <= ent_age[k] - 1'b1;
            end
        end
        for (int i = 0; i < ID_WIDTH; i++) begin
            if (wr_valid[i]) begin
                ent_op[alloc_idx[i]]       <= wr_op[i];
                ent_dst[alloc_idx[i]]      <= wr_dst[i];
                ent_src1[alloc_idx[i]]     <= wr_src1[i];
                ent_src2[alloc_idx[i]]     <= wr_src2[i];
                ent_src1_rdy[alloc_idx[i]] <= wr_src1_rdy[i]
                                           || tag_hit(wr_src1[i], cmp_valid, cmp_dst);
                ent_src2_rdy[alloc_idx[i]] <= wr_src2_rdy[i]
                                           || tag_hit(wr_src2[i], cmp_valid, cmp_dst);
                ent_age[alloc_idx[i]]      <= alloc_age[i];
            end
        end
    end

    // Dispatch only writes when a full group fits
    a_no_overfill: assert property (
        @(posedge clk) disable iff (rst)
        any_wr |-> free_cnt >= RS_CNT_WIDTH'(ID_WIDTH)
    );

    // Ages of live entries stay packed below the live count
    generate for (genvar k = 0; k < RS_DEPTH; k++) begin : g_chk_age
        a_age_in_range: assert property (
            @(posedge clk) disable iff (rst)
            ent_valid[k] |-> ent_age[k] < used_cnt
        );
    end endgenerate

endmodule

`default_nettype wire

//--- tb_ooo_backend.sv
`default_nettype none
`timescale 1ns/1ps

module tb_ooo_backend
    import cpu_params_pkg::*;
    import uop_types_pkg::*;
;

    localparam int N_RAND      = 48;
    localparam int N_OPS       = N_RAND + 10;           // Random ops, then the MEM fill phase
    localparam int NUM_TAGS    = 31;                    // Tag 0 is the always-ready tag
    localparam int H_IDX       = N_RAND + 3;            // Producer of the held tag
    localparam int M_BLK       = N_RAND + 8;            // First op of the blocked MEM group
    localparam int TIMEOUT_CYC = 48 * (RS_DEPTH + MAX_LAT + 4);

    logic                  clk;
    logic                  rst;
    logic                  prv_valid;
    logic                  prv_ready;
    logic                  uops_valid   [ID_WIDTH];
    rs_type_e              uop_type     [ID_WIDTH];
    op_e                   uop_op       [ID_WIDTH];
    logic [TAG_WIDTH-1:0]  uop_dst      [ID_WIDTH];
    logic [TAG_WIDTH-1:0]  uop_src1     [ID_WIDTH];
    logic                  uop_src1_rdy [ID_WIDTH];
    logic [TAG_WIDTH-1:0]  uop_src2     [ID_WIDTH];
    logic                  uop_src2_rdy [ID_WIDTH];
    logic                  cmp_valid    [NUM_RS];
    logic [TAG_WIDTH-1:0]  cmp_dst      [NUM_RS];
    op_e                   cmp_op       [NUM_RS];
    logic [PERF_WIDTH-1:0] perf_block   [NUM_RS];

    // Model of every micro-op in program order
    rs_type_e    m_cls   [N_OPS];
    op_e         m_op    [N_OPS];
    int          m_src1  [N_OPS];       // -1 means the always-ready tag
    int          m_src2  [N_OPS];
    int          m_acc   [N_OPS];       // Acceptance cycle, -1 until accepted
    int          m_done  [N_OPS];       // First completion cycle
    int          m_ndone [N_OPS];
    int          tag_owner [1 << TAG_WIDTH];
    int          slot_idx  [ID_WIDTH];
    int          last_rdy  [NUM_RS];
    int          blk_cyc [$];
    rs_type_e    blk_cls [$];
    int          cyc;
    int          errors;
    int          checks;
    int          done_total;
    logic [31:0] rnd;

    ooo_backend_top DUT (
        .clk, .rst,
        .prv_valid, .prv_ready, .uops_valid,
        .uop_type, .uop_op, .uop_dst,
        .uop_src1, .uop_src1_rdy, .uop_src2, .uop_src2_rdy,
        .cmp_valid, .cmp_dst, .cmp_op,
        .perf_block
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int class_lat(input rs_type_e c);
        case (c)
            RS_INT:  return LAT_INT;
            RS_INTM: return LAT_INTM;
            RS_BR:   return LAT_BR;
            default: return LAT_MEM;
        endcase
    endfunction

    function automatic logic [TAG_WIDTH-1:0] tag_of(input int n);
        if (n < 0) begin
            return '0;
        end
        return TAG_WIDTH'(1 + n % NUM_TAGS);  // Tags 1..31 in turn
    endfunction

    function automatic logic src_done(input int s);
        return (s < 0) || (m_done[s] >= 0);
    endfunction

    // Written the cycle after acceptance, woken the cycle after the later source
    function automatic int earliest_done(input int n);
        int t;
        t = m_acc[n];
        if (m_src1[n] >= 0 && m_done[m_src1[n]] > t) begin
            t = m_done[m_src1[n]];
        end
        if (m_src2[n] >= 0 && m_done[m_src2[n]] > t) begin
            t = m_done[m_src2[n]];
        end
        return t + 1 + class_lat(m_cls[n]);
    endfunction

    function automatic logic rdy_at_accept(input int n);
        logic r;
        r = 1'b1;
        if (m_src1[n] >= 0) begin
            r = r && m_done[m_src1[n]] >= 0 && m_done[m_src1[n]] <= m_acc[n];
        end
        if (m_src2[n] >= 0) begin
            r = r && m_done[m_src2[n]] >= 0 && m_done[m_src2[n]] <= m_acc[n];
        end
        return r;
    endfunction

    // Live entries of a station in cycle t, issue is LAT cycles before completion
    function automatic int occupancy(input rs_type_e c, input int t);
        int occ;
        occ = 0;
        for (int n = 0; n < N_OPS; n++) begin
            if (m_cls[n] == c && m_acc[n] >= 0 && m_acc[n] < t
                && m_done[n] - class_lat(c) >= t) begin
                occ++;
            end
        end
        return occ;
    endfunction

    task automatic set_op(input int n, input rs_type_e c, input op_e o,
                          input int s1, input int s2);
        m_cls[n]  = c;
        m_op[n]   = o;
        m_src1[n] = s1;
        m_src2[n] = s2;
    endtask

    task automatic build_ops();
        int back;
        for (int n = 0; n < N_RAND; n++) begin
            rnd  = xorshift32(rnd);
            back = (n < 8) ? n : 8;             // Sources from the last eight ops
            m_cls[n] = rs_type_e'(rnd[1:0]);
            case (m_cls[n])
                RS_INT:  m_op[n] = rnd[2] ? OP_SUB : OP_ADD;
                RS_INTM: m_op[n] = OP_MUL;
                RS_BR:   m_op[n] = OP_BEQ;
                default: m_op[n] = rnd[2] ? OP_ST : OP_LD;
            endcase
            m_src1[n] = -1;
            m_src2[n] = -1;
            if (back != 0 && rnd[5:4] != 2'd0) begin
                m_src1[n] = n - 1 - int'(rnd[15:8]) % back;
            end
            if (back != 0 && rnd[7:6] == 2'd0) begin
                m_src2[n] = n - 1 - int'(rnd[23:16]) % back;
            end
        end
        // INTM chain delays the held tag, six MEM ops wait on it
        set_op(N_RAND,     RS_INTM, OP_MUL, -1, -1);
        set_op(N_RAND + 1, RS_INTM, OP_MUL, N_RAND, -1);
        set_op(N_RAND + 2, RS_INTM, OP_MUL, N_RAND + 1, -1);
        set_op(H_IDX,      RS_INT,  OP_ADD, N_RAND + 2, -1);
        for (int n = N_RAND + 4; n < N_OPS; n++) begin
            set_op(n, RS_MEM, (n % 2 != 0) ? OP_ST : OP_LD, H_IDX, -1);
        end
        for (int n = 0; n < N_OPS; n++) begin
            m_acc[n]   = -1;
            m_done[n]  = -1;
            m_ndone[n] = 0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // Entered and left 10 ns after a rising edge
    task automatic send_group(input int first);
        int   n;
        logic accepted;
        prv_valid = 1'b0;
        for (int i = 0; i < ID_WIDTH; i++) begin
            while (first + i >= NUM_TAGS && m_done[first + i - NUM_TAGS] < 0) begin
                @(posedge clk);
                #10;
            end
        end
        for (int i = 0; i < ID_WIDTH; i++) begin
            n = first + i;
            slot_idx[i]          = n;
            tag_owner[tag_of(n)] = n;
            uops_valid[i]        = 1'b1;
            uop_type[i]          = m_cls[n];
            uop_op[i]            = m_op[n];
            uop_dst[i]           = tag_of(n);
            uop_src1[i]          = tag_of(m_src1[n]);
            uop_src2[i]          = tag_of(m_src2[n]);
        end
        prv_valid = 1'b1;
        accepted  = 1'b0;
        while (!accepted) begin
            for (int i = 0; i < ID_WIDTH; i++) begin
                uop_src1_rdy[i] = src_done(m_src1[slot_idx[i]]);
                uop_src2_rdy[i] = src_done(m_src2[slot_idx[i]]);
            end
            @(negedge clk);
            accepted = prv_ready;
            @(posedge clk);
            #10;
        end
        prv_valid = 1'b0;
    endtask

    task automatic wait_all_done(input int count);
        while (done_total < count) begin
            @(posedge clk);
            #10;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checkers
    //////////////////////////////////////////////////////////////////////

    task automatic check_completion(input int c);
        int n;
        n = tag_owner[cmp_dst[c]];
        checks++;
        if (n < 0 || m_acc[n] < 0) begin
            errors++;
            $display("Lane %0d completed tag %0d at %0t, which was never dispatched",
                     c, cmp_dst[c], $time);
        end else begin
            if (m_ndone[n] != 0) begin
                errors++;
                $display("Micro-op %0d (tag %0d) completed a second time at %0t",
                         n, cmp_dst[c], $time);
            end else begin
                m_done[n] = cyc;
                done_total++;
            end
            m_ndone[n]++;
            if (rs_type_e'(c) != m_cls[n]) begin
                errors++;
                $display("ERROR t=%0t cmp_valid lane of tag %0d: got %0d expected %0d",
                         $time, cmp_dst[c], c, m_cls[n]);
            end
            if (cmp_op[c] != m_op[n]) begin
                errors++;
                $display("ERROR t=%0t cmp_op[%0d]: got %s expected %s",
                         $time, c, cmp_op[c].name(), m_op[n].name());
            end
            if (!src_done(m_src1[n]) || !src_done(m_src2[n])) begin
                errors++;
                $display("Micro-op %0d completed at %0t before its sources", n, $time);
            end else if (cyc < earliest_done(n)) begin
                errors++;
                $display("ERROR t=%0t completion cycle of micro-op %0d: got %0d expected >= %0d",
                         $time, n, cyc, earliest_done(n));
            end else if (rdy_at_accept(n)) begin
                if (n < last_rdy[m_cls[n]]) begin
                    errors++;
                    $display("Micro-op %0d completed after younger ready micro-op %0d",
                             n, last_rdy[m_cls[n]]);
                end
                last_rdy[m_cls[n]] = n;
            end
        end
    endtask

    always @(negedge clk) begin : monitor
        if (!rst) begin
            if (prv_valid && prv_ready) begin
                for (int i = 0; i < ID_WIDTH; i++) begin
                    if (uops_valid[i]) begin
                        m_acc[slot_idx[i]] = cyc;
                    end
                end
            end
            if (prv_valid && !prv_ready) begin
                blk_cyc.push_back(cyc);
                blk_cls.push_back(uop_type[0]);
            end
            for (int c = 0; c < NUM_RS; c++) begin
                if (cmp_valid[c]) begin
                    check_completion(c);
                end
            end
            cyc++;
        end
    end

    task automatic check_after_reset();
        checks++;
        if (prv_ready !== 1'b1) begin
            errors++;
            $display("ERROR t=%0t prv_ready: got %b expected 1", $time, prv_ready);
        end
        for (int c = 0; c < NUM_RS; c++) begin
            if (cmp_valid[c] !== 1'b0) begin
                errors++;
                $display("ERROR t=%0t cmp_valid[%0d]: got %b expected 0", $time, c, cmp_valid[c]);
            end
            if (perf_block[c] !== '0) begin
                errors++;
                $display("ERROR t=%0t perf_block[%0d]: got %0d expected 0", $time, c, perf_block[c]);
            end
        end
    endtask

    task automatic final_checks();
        int exp_blk [NUM_RS];
        for (int n = 0; n < N_OPS; n++) begin
            checks++;
            if (m_ndone[n] != 1) begin
                errors++;
                $display("Micro-op %0d completed %0d times instead of once", n, m_ndone[n]);
            end
        end
        // The MEM group cannot enter before the held tag lets the station drain
        checks++;
        if (m_acc[M_BLK] <= m_done[H_IDX]) begin
            errors++;
            $display("MEM group accepted in cycle %0d while the station was full until %0d",
                     m_acc[M_BLK], m_done[H_IDX]);
        end
        for (int c = 0; c < NUM_RS; c++) begin
            exp_blk[c] = 0;
        end
        for (int k = 0; k < blk_cyc.size(); k++) begin
            if (occupancy(blk_cls[k], blk_cyc[k]) > RS_DEPTH - ID_WIDTH) begin
                exp_blk[blk_cls[k]]++;      // Slot 0 itself was stalled
            end
        end
        for (int c = 0; c < NUM_RS; c++) begin
            checks++;
            if (perf_block[c] != PERF_WIDTH'(exp_blk[c])) begin
                errors++;
                $display("ERROR t=%0t perf_block[%0d]: got %0d expected %0d",
                         $time, c, perf_block[c], exp_blk[c]);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////////////////////////

    initial begin : watchdog
        wait (cyc >= TIMEOUT_CYC);
        $display("Timeout after %0d cycles with %0d of %0d micro-ops completed",
                 cyc, done_total, N_OPS);
        $display("Verification failed");
        $finish;
    end

    initial begin : stimulus
        rst        = 1'b1;
        prv_valid  = 1'b0;
        cyc        = 0;
        errors     = 0;
        checks     = 0;
        done_total = 0;
        rnd        = 32'd13;
        for (int i = 0; i < ID_WIDTH; i++) begin
            uops_valid[i]   = 1'b1;             // prv_ready then reflects the INT station
            uop_type[i]     = RS_INT;
            uop_op[i]       = OP_ADD;
            uop_dst[i]      = '0;
            uop_src1[i]     = '0;
            uop_src2[i]     = '0;
            uop_src1_rdy[i] = 1'b1;
            uop_src2_rdy[i] = 1'b1;
            slot_idx[i]     = 0;
        end
        for (int t = 0; t < (1 << TAG_WIDTH); t++) begin
            tag_owner[t] = -1;
        end
        for (int c = 0; c < NUM_RS; c++) begin
            last_rdy[c] = -1;
        end
        build_ops();
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;
        @(negedge clk);
        check_after_reset();
        @(posedge clk);
        #10;
        for (int g = 0; g < N_RAND; g += ID_WIDTH) begin
            send_group(g);
        end
        wait_all_done(N_RAND);
        for (int g = N_RAND; g < N_OPS; g += ID_WIDTH) begin
            send_group(g);
        end
        wait_all_done(N_OPS);
        repeat (2 * MAX_LAT) @(posedge clk);    // Room for stray completions
        @(negedge clk);
        final_checks();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uop_types_pkg.sv
`default_nettype none

package uop_types_pkg;

    // Reservation station class, value doubles as station index
    typedef enum logic [1:0] {
        RS_INT  = 2'd0,
        RS_INTM = 2'd1,
        RS_BR   = 2'd2,
        RS_MEM  = 2'd3
    } rs_type_e;

    // Opcode, carried through to completion
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,     // INT
        OP_SUB = 3'd1,     // INT
        OP_MUL = 3'd2,     // INTM
        OP_BEQ = 3'd3,     // BR
        OP_LD  = 3'd4,     // MEM
        OP_ST  = 3'd5      // MEM
    } op_e;

endpackage

`default_nettype wire
